/* flist.f */
+incdir+hw
hw/lvda_pkg.sv
hw/lvda_timing.sv
hw/lvda_credit_fifo.sv
hw/lvda_int_countdown.sv
hw/lvda_addr_decode.sv
hw/lvda_top.sv
tests/lvda_sva.sv
tests/lvda_tb.sv

/* tests/lvda_tb.sv */
`default_nettype none

`include "lvda_defs.svh"

module lvda_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import lvda_pkg::*;

    localparam int         TIMEOUT   = 200; // cycles allowed per wait
    localparam lvda_word_t LOW_MASK  = lvda_word_t'((1 << (`LVDA_WORD_W - 3)) - 1);
    localparam lvda_int_t  TIMER_INT = lvda_int_t'(1 << (`LVDA_INT_W - 1));

    logic       sim_clk;
    logic       rst;
    logic       cmd_valid;
    logic       cmd_write;
    lvda_addr_t cmd_addr;
    lvda_word_t cmd_data;
    logic       cmd_credit;
    logic       rsp_valid;
    lvda_word_t rsp_data;
    logic       rsp_err;
    logic       rsp_credit;
    lvda_word_t disc_in;
    lvda_word_t disc_out;
    lvda_int_t  int_req;
    logic       int_line;

    integer     seed = 57;
    int         host_credits;
    int         credit_pulses;
    lvda_rsp_t  rsp_q[$];

    lvda_top u_dut (
        .sim_clk    (sim_clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_write  (cmd_write),
        .cmd_addr   (cmd_addr),
        .cmd_data   (cmd_data),
        .cmd_credit (cmd_credit),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_err    (rsp_err),
        .rsp_credit (rsp_credit),
        .disc_in    (disc_in),
        .disc_out   (disc_out),
        .int_req    (int_req),
        .int_line   (int_line)
    );

    initial begin
        sim_clk = 1'b0;
        forever #50 sim_clk = ~sim_clk;
    end

    // credits coming back and responses landing in the receive slots
    always @(negedge sim_clk) begin
        if (cmd_credit) begin
            host_credits++;
            credit_pulses++;
        end
        if (rsp_valid) begin
            rsp_q.push_back('{data: rsp_data, err: rsp_err});
        end
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    always @(negedge sim_clk) begin
        if (u_dut.u_sva.fail_count != 0) begin
            abort_run("a bound assertion on the DUT failed");
        end
    end

    task automatic check_word(input lvda_word_t got, input lvda_word_t exp, input string msg);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                $time, msg, got, exp));
        end
    endtask

    task automatic check_int(input lvda_int_t got, input lvda_int_t exp, input string msg);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                $time, msg, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                $time, msg, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string msg);
        if (got != exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
                $time, msg, got, exp));
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge sim_clk);
    endtask

    task automatic send_cmd(input logic write, input lvda_addr_t addr, input lvda_word_t data);
        int waited;
        waited = 0;
        while (host_credits == 0) begin
            if (waited == TIMEOUT) begin
                abort_run("no command credit came back before the timeout");
            end
            @(posedge sim_clk);
            waited++;
        end
        @(posedge sim_clk);
        cmd_valid <= 1'b1;
        cmd_write <= write;
        cmd_addr  <= addr;
        cmd_data  <= data;
        host_credits--;
        @(posedge sim_clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic return_rsp_credit();
        @(posedge sim_clk);
        rsp_credit <= 1'b1;
        @(posedge sim_clk);
        rsp_credit <= 1'b0;
    endtask

    task automatic wait_rsp(output lvda_rsp_t rsp);
        int waited;
        waited = 0;
        while (rsp_q.size() == 0) begin
            if (waited == TIMEOUT) begin
                abort_run($sformatf("no response arrived within %0d cycles", TIMEOUT));
            end
            @(posedge sim_clk);
            waited++;
        end
        rsp = rsp_q.pop_front();
    endtask

    task automatic wait_int();
        int waited;
        waited = 0;
        while (int_line !== 1'b1) begin
            if (waited == TIMEOUT) begin
                abort_run($sformatf("int_line stayed low for %0d cycles", TIMEOUT));
            end
            @(negedge sim_clk);
            waited++;
        end
    endtask

    // status-only responses with the slot handed back right after
    task automatic expect_rsp(input lvda_word_t exp_data, input logic exp_err, input string what);
        lvda_rsp_t rsp;
        wait_rsp(rsp);
        check_flag(rsp.err, exp_err, {what, " err"});
        check_word(rsp.data, exp_data, {what, " data"});
        return_rsp_credit();
    endtask

    task automatic disc_out_write();
        lvda_word_t w;
        @(negedge sim_clk);
        check_word(disc_out, '0, "disc_out after reset");
        check_flag(rsp_valid, 1'b0, "rsp_valid after reset");
        check_flag(int_line, 1'b0, "int_line after reset");
        w = lvda_word_t'($random(seed));
        send_cmd(1'b1, `LVDA_ADDR_DISC_OUT, w);
        expect_rsp('0, 1'b0, "discrete output write");
        @(negedge sim_clk);
        check_word(disc_out, w, "disc_out after write");
    endtask

    task automatic disc_in_read();
        lvda_word_t din;
        lvda_rsp_t  rsp;
        din = lvda_word_t'($random(seed));
        @(posedge sim_clk);
        disc_in <= din;
        send_cmd(1'b0, `LVDA_ADDR_DISC_IN, '0);
        wait_rsp(rsp);
        check_flag(rsp.err, 1'b0, "discrete input read err");
        check_word(rsp.data & LOW_MASK, din & LOW_MASK, "discrete input low bits");
        return_rsp_credit();
        send_cmd(1'b0, 9'h1ff, '0);
        expect_rsp('0, 1'b1, "invalid address");
        send_cmd(1'b1, `LVDA_ADDR_DISC_IN, lvda_word_t'($random(seed)));
        expect_rsp('0, 1'b1, "write to read-only address");
    endtask

    task automatic countdown_interrupt();
        lvda_rsp_t rsp;
        send_cmd(1'b1, `LVDA_ADDR_CNT_LOAD, lvda_word_t'(3));
        expect_rsp('0, 1'b0, "countdown load");
        wait_int();
        send_cmd(1'b0, `LVDA_ADDR_INT_READ, '0);
        wait_rsp(rsp);
        check_flag(rsp.err, 1'b0, "interrupt read err");
        check_int(lvda_int_t'(rsp.data), TIMER_INT, "timer interrupt");
        return_rsp_credit();
        send_cmd(1'b0, `LVDA_ADDR_INT_READ, '0);
        wait_rsp(rsp);
        check_int(lvda_int_t'(rsp.data), '0, "latch after clear");
        return_rsp_credit();
    endtask

    task automatic int_mask_gating();
        lvda_rsp_t rsp;
        send_cmd(1'b1, `LVDA_ADDR_INT_MASK, '0);
        expect_rsp('0, 1'b0, "mask clear");
        @(posedge sim_clk);
        int_req <= lvda_int_t'(8'h04);
        @(posedge sim_clk);
        int_req <= '0;
        idle_cycles(4);
        @(negedge sim_clk);
        check_flag(int_line, 1'b0, "int_line with mask clear");
        send_cmd(1'b1, `LVDA_ADDR_INT_MASK, lvda_word_t'({`LVDA_INT_W{1'b1}}));
        expect_rsp('0, 1'b0, "mask set");
        wait_int();
        send_cmd(1'b0, `LVDA_ADDR_INT_READ, '0);
        wait_rsp(rsp);
        check_int(lvda_int_t'(rsp.data), lvda_int_t'(8'h04), "external interrupt 2");
        return_rsp_credit();
        @(negedge sim_clk);
        check_flag(int_line, 1'b0, "int_line after latch read");
    endtask

    task automatic credit_backpressure();
        int         start_pulses;
        int         waited;
        int         i;
        lvda_word_t w;
        lvda_word_t last;
        lvda_rsp_t  rsp;
        start_pulses = credit_pulses;
        last = disc_out;
        for (i = 0; i < `LVDA_CMD_DEPTH; i++) begin
            w = lvda_word_t'($random(seed));
            if (i % 2 == 0) begin
                send_cmd(1'b1, `LVDA_ADDR_DISC_OUT, w);
                last = w;
            end else begin
                send_cmd(1'b1, `LVDA_ADDR_DISC_IN, w); // odd ones answer with err
            end
        end
        waited = 0;
        while (host_credits != `LVDA_CMD_DEPTH) begin
            if (waited == TIMEOUT) begin
                abort_run("commands were not all executed before the timeout");
            end
            @(posedge sim_clk);
            waited++;
        end
        idle_cycles(4);
        check_count(rsp_q.size(), `LVDA_RSP_CREDITS, "responses sent without new credits");
        for (i = 0; i < `LVDA_CMD_DEPTH; i++) begin
            wait_rsp(rsp);
            check_flag(rsp.err, logic'(i % 2), $sformatf("response %0d err", i));
            check_word(rsp.data, '0, $sformatf("response %0d data", i));
            return_rsp_credit();
        end
        idle_cycles(4);
        check_count(rsp_q.size(), 0, "extra responses");
        check_count(credit_pulses - start_pulses, `LVDA_CMD_DEPTH, "cmd_credit pulses");
        @(negedge sim_clk);
        check_word(disc_out, last, "disc_out after burst");
    endtask

    initial begin
        rst           = 1'b1;
        cmd_valid     = 1'b0;
        cmd_write     = 1'b0;
        cmd_addr      = '0;
        cmd_data      = '0;
        rsp_credit    = 1'b0;
        disc_in       = '0;
        int_req       = '0;
        host_credits  = `LVDA_CMD_DEPTH;
        credit_pulses = 0;
        repeat (4) @(posedge sim_clk);
        rst <= 1'b0;

        disc_out_write();
        disc_in_read();
        countdown_interrupt();
        int_mask_gating();
        credit_backpressure();

        if (u_dut.u_sva.fail_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("test failed");
            $fatal(1, "a bound assertion on the DUT failed");
        end
    end

endmodule

`default_nettype wire

/* tests/lvda_sva.sv */
`default_nettype none

`include "lvda_defs.svh"

module lvda_sva (
    input wire logic sim_clk,
    input wire logic rst,
    input wire logic cmd_valid,
    input wire logic cmd_full,
    input wire logic cmd_credit,
    input wire logic rsp_valid,
    input wire logic rsp_credit,
    input wire logic int_line
);

    timeunit 1ns;
    timeprecision 100ps;

    int crd; // credits the DUT should hold toward the host
    int fail_count = 0;

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            crd <= `LVDA_RSP_CREDITS;
        end else begin
            crd <= crd + int'(rsp_credit) - int'(rsp_valid);
        end
    end

    a_cmd_room: assert property (@(posedge sim_clk) disable iff (rst)
        cmd_valid |-> !cmd_full)
        else begin
            fail_count++;
            $error("command arrived while the command buffer was full");
        end

    a_rsp_credit: assert property (@(posedge sim_clk) disable iff (rst)
        rsp_valid |-> (crd != 0))
        else begin
            fail_count++;
            $error("response sent with no response credit left");
        end

    a_reset_quiet: assert property (@(posedge sim_clk)
        rst |=> (!cmd_credit && !rsp_valid && !int_line))
        else begin
            fail_count++;
            $error("outputs not quiet in the cycle after reset");
        end

endmodule

bind lvda_top lvda_sva u_sva (
    .sim_clk    (sim_clk),
    .rst        (rst),
    .cmd_valid  (cmd_valid),
    .cmd_full   (cmd_full),
    .cmd_credit (cmd_credit),
    .rsp_valid  (rsp_valid),
    .rsp_credit (rsp_credit),
    .int_line   (int_line)
);

`default_nettype wire

/* hw/lvda_top.sv */
`default_nettype none

`include "lvda_defs.svh"

module lvda_top (
    input  wire logic                 sim_clk,
    input  wire logic                 rst,
    input  wire logic                 cmd_valid,
    input  wire logic                 cmd_write,
    input  wire lvda_pkg::lvda_addr_t cmd_addr,
    input  wire lvda_pkg::lvda_word_t cmd_data,
    output logic                      cmd_credit,
    output logic                      rsp_valid,
    output lvda_pkg::lvda_word_t      rsp_data,
    output logic                      rsp_err,
    input  wire logic                 rsp_credit,
    input  wire lvda_pkg::lvda_word_t disc_in,
    output lvda_pkg::lvda_word_t      disc_out,
    input  wire lvda_pkg::lvda_int_t  int_req,
    output logic                      int_line
);

    import lvda_pkg::*;

    logic       phase_tick;
    logic [2:0] bit_time;
    lvda_cmd_t  cmd_in;
    lvda_cmd_t  cmd_head;
    logic       cmd_empty;
    logic       cmd_full;
    logic       cmd_pop;
    logic       rsp_push;
    lvda_rsp_t  rsp_push_data;
    lvda_rsp_t  rsp_head;
    logic       rsp_full;
    logic       rsp_empty;
    logic       rsp_pop;
    logic       cnt_load;
    lvda_word_t load_value;
    logic       int_read;
    logic       mask_write;
    lvda_word_t cnt_value;
    lvda_int_t  int_pending;

    assign cmd_in     = '{write: cmd_write, addr: cmd_addr, data: cmd_data};
    assign cmd_credit = cmd_pop; // credit back as each command leaves

    lvda_timing u_timing (
        .sim_clk    (sim_clk),
        .rst        (rst),
        .phase_tick (phase_tick),
        .bit_time   (bit_time)
    );

    lvda_credit_fifo #(
        .DEPTH     (`LVDA_CMD_DEPTH),
        .payload_t (lvda_cmd_t)
    ) u_cmd_buf (
        .sim_clk   (sim_clk),
        .rst       (rst),
        .push      (cmd_valid),
        .push_data (cmd_in),
        .pop       (cmd_pop),
        .head      (cmd_head),
        .empty     (cmd_empty),
        .full      (cmd_full)
    );

    lvda_credit_fifo #(
        .DEPTH     (`LVDA_RSP_DEPTH),
        .payload_t (lvda_rsp_t)
    ) u_rsp_buf (
        .sim_clk   (sim_clk),
        .rst       (rst),
        .push      (rsp_push),
        .push_data (rsp_push_data),
        .pop       (rsp_pop),
        .head      (rsp_head),
        .empty     (rsp_empty),
        .full      (rsp_full)
    );

    lvda_int_countdown u_int_cnt (
        .sim_clk     (sim_clk),
        .rst         (rst),
        .phase_tick  (phase_tick),
        .cnt_load    (cnt_load),
        .load_value  (load_value),
        .int_read    (int_read),
        .mask_write  (mask_write),
        .int_req     (int_req),
        .cnt_value   (cnt_value),
        .int_pending (int_pending),
        .int_line    (int_line)
    );

    lvda_addr_decode u_decode (
        .sim_clk       (sim_clk),
        .rst           (rst),
        .phase_tick    (phase_tick),
        .bit_time      (bit_time),
        .cmd_head      (cmd_head),
        .cmd_empty     (cmd_empty),
        .cmd_pop       (cmd_pop),
        .rsp_push      (rsp_push),
        .rsp_push_data (rsp_push_data),
        .rsp_full      (rsp_full),
        .rsp_head      (rsp_head),
        .rsp_empty     (rsp_empty),
        .rsp_pop       (rsp_pop),
        .rsp_credit    (rsp_credit),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .rsp_err       (rsp_err),
        .disc_in       (disc_in),
        .disc_out      (disc_out),
        .cnt_load      (cnt_load),
        .load_value    (load_value),
        .int_read      (int_read),
        .mask_write    (mask_write),
        .cnt_value     (cnt_value),
        .int_pending   (int_pending)
    );

endmodule

`default_nettype wire

/* hw/lvda_addr_decode.sv */
`default_nettype none

`include "lvda_defs.svh"

module lvda_addr_decode (
    input  wire logic                 sim_clk,
    input  wire logic                 rst,
    input  wire logic                 phase_tick,
    input  wire logic [2:0]           bit_time,
    input  wire lvda_pkg::lvda_cmd_t  cmd_head,
    input  wire logic                 cmd_empty,
    output logic                      cmd_pop,
    output logic                      rsp_push,
    output lvda_pkg::lvda_rsp_t       rsp_push_data,
    input  wire logic                 rsp_full,
    input  wire lvda_pkg::lvda_rsp_t  rsp_head,
    input  wire logic                 rsp_empty,
    output logic                      rsp_pop,
    input  wire logic                 rsp_credit,
    output logic                      rsp_valid,
    output lvda_pkg::lvda_word_t      rsp_data,
    output logic                      rsp_err,
    input  wire lvda_pkg::lvda_word_t disc_in,
    output lvda_pkg::lvda_word_t      disc_out,
    output logic                      cnt_load,
    output lvda_pkg::lvda_word_t      load_value,
    output logic                      int_read,
    output logic                      mask_write,
    input  wire lvda_pkg::lvda_word_t cnt_value,
    input  wire lvda_pkg::lvda_int_t  int_pending
);

    import lvda_pkg::*;

    localparam int CRD_W = $clog2(`LVDA_RSP_CREDITS + 1);
    localparam int LOW_W = `LVDA_WORD_W - 3;

    lvda_op_e         op;
    logic             exec;
    logic             read_only;
    lvda_rsp_t        rsp_next;
    logic [CRD_W-1:0] rsp_cnt;

    always_comb begin
        case (cmd_head.addr)
            `LVDA_ADDR_DISC_OUT: op = OP_DISC_OUT;
            `LVDA_ADDR_DISC_IN:  op = OP_DISC_IN;
            `LVDA_ADDR_CNT_LOAD: op = OP_CNT_LOAD;
            `LVDA_ADDR_CNT_READ: op = OP_CNT_READ;
            `LVDA_ADDR_INT_READ: op = OP_INT_READ;
            `LVDA_ADDR_INT_MASK: op = OP_INT_MASK;
            default:             op = OP_INVALID;
        endcase
    end

    assign read_only = (op == OP_DISC_IN) || (op == OP_CNT_READ) || (op == OP_INT_READ);

    // one command per strobe, held off while the response side is full
    assign exec    = phase_tick & ~cmd_empty & ~rsp_full;
    assign cmd_pop = exec;

    assign cnt_load   = exec & cmd_head.write & (op == OP_CNT_LOAD);
    assign mask_write = exec & cmd_head.write & (op == OP_INT_MASK);
    assign int_read   = exec & ~cmd_head.write & (op == OP_INT_READ);
    assign load_value = cmd_head.data;

    always_comb begin
        rsp_next.data = '0;
        rsp_next.err  = 1'b0;
        if (op == OP_INVALID || (cmd_head.write && read_only)) begin
            rsp_next.err = 1'b1;
        end else if (!cmd_head.write) begin
            case (op)
                OP_DISC_OUT: rsp_next.data = disc_out;
                OP_DISC_IN:  rsp_next.data = {bit_time, disc_in[LOW_W-1:0]};
                OP_CNT_LOAD,
                OP_CNT_READ: rsp_next.data = cnt_value;
                OP_INT_READ: rsp_next.data = lvda_word_t'(int_pending);
                default:     ; // mask is write-only, reads back zero
            endcase
        end
    end

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            disc_out <= '0;
            rsp_push <= 1'b0;
        end else begin
            rsp_push <= exec; // lands one cycle after execute
            if (exec && cmd_head.write && op == OP_DISC_OUT) begin
                disc_out <= cmd_head.data;
            end
        end
    end

    always_ff @(posedge sim_clk) begin
        if (exec) begin
            rsp_push_data <= rsp_next;
        end
    end

    // response credits held toward the host
    assign rsp_pop   = ~rsp_empty & (rsp_cnt != '0);
    assign rsp_valid = rsp_pop;
    assign rsp_data  = rsp_head.data;
    assign rsp_err   = rsp_head.err;

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            rsp_cnt <= CRD_W'(`LVDA_RSP_CREDITS);
        end else begin
            case ({rsp_credit, rsp_pop})
                2'b10:   rsp_cnt <= rsp_cnt + CRD_W'(1);
                2'b01:   rsp_cnt <= rsp_cnt - CRD_W'(1);
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/lvda_int_countdown.sv */
`default_nettype none

`include "lvda_defs.svh"

module lvda_int_countdown (
    input  wire logic                sim_clk,
    input  wire logic                rst,
    input  wire logic                phase_tick,
    input  wire logic                cnt_load,
    input  wire lvda_pkg::lvda_word_t load_value,
    input  wire logic                int_read,
    input  wire logic                mask_write,
    input  wire lvda_pkg::lvda_int_t  int_req,
    output lvda_pkg::lvda_word_t     cnt_value,
    output lvda_pkg::lvda_int_t      int_pending,
    output logic                     int_line
);

    import lvda_pkg::*;

    localparam int TIMER_BIT = `LVDA_INT_W - 1;

    lvda_word_t cnt_q;
    lvda_int_t  latch_q;
    lvda_int_t  mask_q;
    lvda_int_t  int_set;
    lvda_int_t  int_clr;
    logic       timer_fire;

    assign cnt_value   = cnt_q;
    assign int_pending = latch_q & mask_q;
    assign int_line    = |int_pending;

    // step from 1 to 0 on a strobe, unless a reload wins
    assign timer_fire = phase_tick & ~cnt_load & (cnt_q == lvda_word_t'(1));

    always_comb begin
        int_set            = int_req;
        int_set[TIMER_BIT] = timer_fire; // top bit is internal only
    end

    // only what the host saw gets cleared
    assign int_clr = int_read ? int_pending : '0;

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (cnt_load) begin
            cnt_q <= load_value;
        end else if (phase_tick && cnt_q != '0) begin
            cnt_q <= cnt_q - lvda_word_t'(1);
        end
    end

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            latch_q <= '0;
        end else begin
            latch_q <= (latch_q & ~int_clr) | int_set; // new request beats the clear
        end
    end

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            mask_q <= '1;
        end else if (mask_write) begin
            mask_q <= load_value[`LVDA_INT_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* hw/lvda_credit_fifo.sv */
`default_nettype none

module lvda_credit_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic
) (
    input  wire logic     sim_clk,
    input  wire logic     rst,
    input  wire logic     push,
    input  wire payload_t push_data,
    input  wire logic     pop,
    output payload_t      head,
    output logic          empty,
    output logic          full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;
    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign head    = mem[rd_ptr];

    always_ff @(posedge sim_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + PTR_W'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: ; // both or neither keeps occupancy
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/lvda_timing.sv */
`default_nettype none

`include "lvda_defs.svh"

module lvda_timing (
    input  wire logic       sim_clk,
    input  wire logic       rst,
    output logic            phase_tick,
    output logic [2:0]      bit_time
);

    localparam int DIV_W = $clog2(`LVDA_PHASE_DIV);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`LVDA_PHASE_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    logic             div_wrap;

    assign div_wrap = (div_cnt == DIV_LAST);

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            div_cnt    <= '0;
            phase_tick <= 1'b0;
            bit_time   <= '0;
        end else begin
            phase_tick <= div_wrap; // one strobe per divider period
            if (div_wrap) begin
                div_cnt  <= '0;
                bit_time <= bit_time + 3'd1;
            end else begin
                div_cnt <= div_cnt + DIV_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

/* hw/lvda_pkg.sv */
`default_nettype none

`include "lvda_defs.svh"

package lvda_pkg;

    typedef logic [`LVDA_WORD_W-1:0] lvda_word_t;
    typedef logic [`LVDA_ADDR_W-1:0] lvda_addr_t;
    typedef logic [`LVDA_INT_W-1:0] lvda_int_t; // bit 7 is the timer

    typedef struct packed {
        logic       write;
        lvda_addr_t addr;
        lvda_word_t data;
    } lvda_cmd_t;

    typedef struct packed {
        lvda_word_t data;
        logic       err;
    } lvda_rsp_t;

    typedef enum logic [2:0] {
        OP_DISC_OUT,
        OP_DISC_IN,
        OP_CNT_LOAD,
        OP_CNT_READ,
        OP_INT_READ,
        OP_INT_MASK,
        OP_INVALID
    } lvda_op_e;

endpackage

`default_nettype wire

/* hw/lvda_defs.svh */
`ifndef LVDA_DEFS_SVH
`define LVDA_DEFS_SVH

// widths
`define LVDA_WORD_W 26
`define LVDA_ADDR_W 9
`define LVDA_INT_W 8

// buffer depths and credits
`define LVDA_CMD_DEPTH 4
`define LVDA_RSP_DEPTH 4
`define LVDA_RSP_CREDITS 2

`define LVDA_PHASE_DIV 8

// register map
`define LVDA_ADDR_DISC_OUT 9'h040
`define LVDA_ADDR_DISC_IN 9'h041
`define LVDA_ADDR_CNT_LOAD 9'h050
`define LVDA_ADDR_CNT_READ 9'h051
`define LVDA_ADDR_INT_READ 9'h060
`define LVDA_ADDR_INT_MASK 9'h061

`endif
